//--- verilog/cpu_pkg.sv
package cpu_pkg;

    // ========================================================================
    // memory stage to write-back stage
    // ========================================================================
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        ertn;
        logic [4:0]  dest;
        logic        rf_we;
        logic        res_from_csr;
        logic [31:0] result;
        logic        excp;
        logic [15:0] excp_num;      // bit 15 wins
        logic [31:0] err_addr;      // bad address for ADE/ALE
        logic        csr_we;
        logic [13:0] csr_num;
        logic [31:0] csr_wmask;
        logic [31:0] csr_wdata;
    } ms_to_ws_t;

    // register file write port
    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } wb_bus_t;

    // bypass back to decode
    typedef struct packed {
        logic        valid;
        logic        rf_we;
        logic [4:0]  dest;
        logic [31:0] result;
    } ws_forward_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rf_we;         // byte enables, all or none
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
        logic [31:0] inst;
    } debug_trace_t;

endpackage

//--- verilog/csr_pkg.sv
package csr_pkg;

    // ========================================================================
    // CSR addresses
    // ========================================================================
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;

    // exception codes as written to ESTAT.Ecode
    localparam logic [5:0] ECODE_INT  = 6'h00;
    localparam logic [5:0] ECODE_PIL  = 6'h01;
    localparam logic [5:0] ECODE_PIS  = 6'h02;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_PME  = 6'h04;
    localparam logic [5:0] ECODE_PPI  = 6'h07;
    localparam logic [5:0] ECODE_ADE  = 6'h08;
    localparam logic [5:0] ECODE_ALE  = 6'h09;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_IPE  = 6'h0e;
    localparam logic [5:0] ECODE_TLBR = 6'h3f;

    // ========================================================================
    // requests from write-back into the CSR file
    // ========================================================================
    typedef struct packed {
        logic        we;
        logic [13:0] num;
        logic [31:0] wmask;
        logic [31:0] wdata;
    } csr_wreq_t;

    typedef struct packed {
        logic        excp_flush;
        logic        ertn_flush;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] epc;
        logic [31:0] eaddr;
    } excp_req_t;

endpackage

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic             clk,
    input  cpu_pkg::wb_bus_t wb_bus,
    input  logic [4:0]       raddr1,
    input  logic [4:0]       raddr2,
    output logic [31:0]      rdata1,
    output logic [31:0]      rdata2
);

    logic [31:0] rf [0:31];

    // ========================================================================
    // write port
    // ========================================================================
    always_ff @(posedge clk) begin
        if (wb_bus.we && wb_bus.waddr != 5'd0) begin
            rf[wb_bus.waddr] <= wb_bus.wdata;
        end
    end

    // ========================================================================
    // read ports
    // ========================================================================
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];   // r0 hardwired
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

    // dest comes from the latched bundle upstream
    a_waddr_known: assert property (@(posedge clk)
        wb_bus.we |-> !$isunknown(wb_bus.waddr));

endmodule

//--- verilog/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic               clk,
    input  logic               reset,
    input  logic [13:0]        csr_raddr,
    output logic [31:0]        csr_rdata,
    input  csr_pkg::csr_wreq_t csr_wreq,
    input  csr_pkg::excp_req_t excp_req,
    input  logic [7:0]         hard_int_in,
    input  logic               ipi_int_in,
    output logic [31:0]        era,
    output logic [31:0]        eentry,
    output logic               has_int
);

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_is_sw;
    logic [7:0]  estat_is_hw;
    logic        estat_is_ipi;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [12:0] estat_is;
    logic [31:0] era_r;
    logic [31:0] badv_r;
    logic [25:0] eentry_va;
    logic [31:0] save_r [0:3];
    logic [31:0] wr_old;
    logic [31:0] wr_val;

    // IS[11] timer and IS[10] not implemented
    assign estat_is = {estat_is_ipi, 2'b00, estat_is_hw, estat_is_sw};

    function automatic logic [31:0] csr_read(input logic [13:0] addr);
        case (addr)
            csr_pkg::CSR_CRMD:   return {29'd0, crmd_ie, crmd_plv};
            csr_pkg::CSR_PRMD:   return {29'd0, prmd_pie, prmd_pplv};
            csr_pkg::CSR_ECFG:   return {19'd0, ecfg_lie};
            csr_pkg::CSR_ESTAT:  return {1'b0, estat_esubcode, estat_ecode, 3'd0, estat_is};
            csr_pkg::CSR_ERA:    return era_r;
            csr_pkg::CSR_BADV:   return badv_r;
            csr_pkg::CSR_EENTRY: return {eentry_va, 6'd0};
            csr_pkg::CSR_SAVE0:  return save_r[0];
            csr_pkg::CSR_SAVE1:  return save_r[1];
            csr_pkg::CSR_SAVE2:  return save_r[2];
            csr_pkg::CSR_SAVE3:  return save_r[3];
            default:             return 32'd0;
        endcase
    endfunction

    always_comb begin
        csr_rdata = csr_read(csr_raddr);
        wr_old    = csr_read(csr_wreq.num);
    end

    // old bits where mask is clear
    assign wr_val = (wr_old & ~csr_wreq.wmask) | (csr_wreq.wdata & csr_wreq.wmask);

    // ========================================================================
    // control registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv       <= 2'd0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'd0;
            prmd_pie       <= 1'b0;
            ecfg_lie       <= 13'd0;
            estat_is_sw    <= 2'd0;
            estat_ecode    <= 6'd0;
            estat_esubcode <= 9'd0;
            era_r          <= 32'd0;
            eentry_va      <= 26'd0;
        end else if (excp_req.excp_flush) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            crmd_plv       <= 2'd0;     // kernel, interrupts off
            crmd_ie        <= 1'b0;
            era_r          <= excp_req.epc;
            estat_ecode    <= excp_req.ecode;
            estat_esubcode <= excp_req.esubcode;
        end else if (excp_req.ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_wreq.we) begin
            case (csr_wreq.num)
                csr_pkg::CSR_CRMD: begin
                    crmd_plv <= wr_val[1:0];
                    crmd_ie  <= wr_val[2];
                end
                csr_pkg::CSR_PRMD: begin
                    prmd_pplv <= wr_val[1:0];
                    prmd_pie  <= wr_val[2];
                end
                csr_pkg::CSR_ECFG:   ecfg_lie    <= wr_val[12:0];
                csr_pkg::CSR_ESTAT:  estat_is_sw <= wr_val[1:0];  // only soft irq bits
                csr_pkg::CSR_ERA:    era_r       <= wr_val;
                csr_pkg::CSR_EENTRY: eentry_va   <= wr_val[31:6];
                default: ;
            endcase
        end
    end

    // interrupt lines sampled every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is_hw  <= 8'd0;
            estat_is_ipi <= 1'b0;
        end else begin
            estat_is_hw  <= hard_int_in;
            estat_is_ipi <= ipi_int_in;
        end
    end

    // ========================================================================
    // data registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (excp_req.excp_flush) begin
            if (excp_req.ecode == csr_pkg::ECODE_ADE || excp_req.ecode == csr_pkg::ECODE_ALE) begin
                badv_r <= excp_req.eaddr;
            end
        end else if (csr_wreq.we) begin
            case (csr_wreq.num)
                csr_pkg::CSR_BADV:  badv_r    <= wr_val;
                csr_pkg::CSR_SAVE0: save_r[0] <= wr_val;
                csr_pkg::CSR_SAVE1: save_r[1] <= wr_val;
                csr_pkg::CSR_SAVE2: save_r[2] <= wr_val;
                csr_pkg::CSR_SAVE3: save_r[3] <= wr_val;
                default: ;
            endcase
        end
    end

    assign era     = era_r;
    assign eentry  = {eentry_va, 6'd0};
    assign has_int = crmd_ie && |(estat_is & ecfg_lie);

    // write-back must drop the CSR write of a flushing instruction
    a_no_wr_on_flush: assert property (@(posedge clk) disable iff (reset)
        (excp_req.excp_flush || excp_req.ertn_flush) |-> !csr_wreq.we);

endmodule

//--- verilog/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t    ms_to_ws_bus,
    output logic                  ws_allowin,
    input  logic [31:0]           csr_rdata,
    output logic [13:0]           csr_raddr,
    output csr_pkg::csr_wreq_t    csr_wreq,
    output csr_pkg::excp_req_t    excp_req,
    output logic                  ws_ex,
    output cpu_pkg::wb_bus_t      wb_bus,
    output cpu_pkg::ws_forward_t  ws_forward,
    output cpu_pkg::debug_trace_t debug_trace
);

    logic               ws_ready_go;
    logic               ws_valid;
    cpu_pkg::ms_to_ws_t ws_bundle;
    logic [5:0]         ecode;
    logic [31:0]        final_result;
    logic               rf_we;

    // ========================================================================
    // pipeline register
    // ========================================================================
    assign ws_ready_go = 1'b1;     // last stage, never waits
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bundle <= ms_to_ws_bus;
        end
    end

    // ========================================================================
    // exception decode
    // ========================================================================
    assign ws_ex = ws_valid && (ws_bundle.excp || ws_bundle.ertn);

    always_comb begin
        if      (ws_bundle.excp_num[15]) ecode = csr_pkg::ECODE_INT;
        else if (ws_bundle.excp_num[14]) ecode = csr_pkg::ECODE_ADE;
        else if (ws_bundle.excp_num[13]) ecode = csr_pkg::ECODE_TLBR;
        else if (ws_bundle.excp_num[12]) ecode = csr_pkg::ECODE_PIF;
        else if (ws_bundle.excp_num[11]) ecode = csr_pkg::ECODE_PPI;
        else if (ws_bundle.excp_num[10]) ecode = csr_pkg::ECODE_SYS;
        else if (ws_bundle.excp_num[9])  ecode = csr_pkg::ECODE_BRK;
        else if (ws_bundle.excp_num[8])  ecode = csr_pkg::ECODE_INE;
        else if (ws_bundle.excp_num[7])  ecode = csr_pkg::ECODE_IPE;
        else if (ws_bundle.excp_num[6])  ecode = csr_pkg::ECODE_ALE;
        else if (ws_bundle.excp_num[5])  ecode = csr_pkg::ECODE_TLBR;  // refill on data side
        else if (ws_bundle.excp_num[4])  ecode = csr_pkg::ECODE_PME;
        else if (ws_bundle.excp_num[3])  ecode = csr_pkg::ECODE_PPI;
        else if (ws_bundle.excp_num[2])  ecode = csr_pkg::ECODE_PIS;
        else if (ws_bundle.excp_num[1])  ecode = csr_pkg::ECODE_PIL;
        else                             ecode = 6'd0;
    end

    assign excp_req.excp_flush = ws_valid && ws_bundle.excp;
    assign excp_req.ertn_flush = ws_valid && ws_bundle.ertn;
    assign excp_req.ecode      = ecode;
    assign excp_req.esubcode   = 9'd0;
    assign excp_req.epc        = ws_bundle.pc;
    assign excp_req.eaddr      = ws_bundle.err_addr;

    // csr access, write dropped on a flush
    assign csr_raddr      = ws_bundle.csr_num;
    assign csr_wreq.we    = ws_valid && ws_bundle.csr_we && !ws_ex;
    assign csr_wreq.num   = ws_bundle.csr_num;
    assign csr_wreq.wmask = ws_bundle.csr_wmask;
    assign csr_wreq.wdata = ws_bundle.csr_wdata;

    // ========================================================================
    // write back
    // ========================================================================
    assign final_result = ws_bundle.res_from_csr ? csr_rdata : ws_bundle.result;
    assign rf_we        = ws_valid && ws_bundle.rf_we && !ws_ex;

    assign wb_bus.we    = rf_we;
    assign wb_bus.waddr = ws_bundle.dest;
    assign wb_bus.wdata = final_result;

    assign ws_forward.valid  = ws_valid;
    assign ws_forward.rf_we  = ws_bundle.rf_we;
    assign ws_forward.dest   = ws_bundle.dest;
    assign ws_forward.result = final_result;

    assign debug_trace.pc       = ws_bundle.pc;
    assign debug_trace.rf_we    = {4{rf_we}};
    assign debug_trace.rf_wnum  = ws_bundle.dest;
    assign debug_trace.rf_wdata = final_result;
    assign debug_trace.inst     = ws_bundle.inst;

    // an instruction is either trapping or returning, not both
    a_excp_ertn_excl: assert property (@(posedge clk) disable iff (reset)
        ms_to_ws_valid && ws_allowin |=> !(ws_bundle.excp && ws_bundle.ertn));

endmodule

//--- verilog/wb_top.sv
`timescale 1ns/1ps

module wb_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ms_to_ws_valid,
    input  cpu_pkg::ms_to_ws_t    ms_to_ws_bus,
    output logic                  ws_allowin,
    input  logic [7:0]            hard_int_in,
    input  logic                  ipi_int_in,
    input  logic [4:0]            raddr1,
    input  logic [4:0]            raddr2,
    output logic [31:0]           rdata1,
    output logic [31:0]           rdata2,
    output cpu_pkg::ws_forward_t  ws_forward,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output logic                  ws_ex,
    output logic [31:0]           era,
    output logic [31:0]           eentry,
    output logic                  has_int,
    output cpu_pkg::debug_trace_t debug_trace
);

    logic [13:0]        csr_raddr;
    logic [31:0]        csr_rdata;
    csr_pkg::csr_wreq_t csr_wreq;
    csr_pkg::excp_req_t excp_req;
    cpu_pkg::wb_bus_t   wb_bus;

    assign excp_flush = excp_req.excp_flush;
    assign ertn_flush = excp_req.ertn_flush;

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .csr_rdata      (csr_rdata),
        .csr_raddr      (csr_raddr),
        .csr_wreq       (csr_wreq),
        .excp_req       (excp_req),
        .ws_ex          (ws_ex),
        .wb_bus         (wb_bus),
        .ws_forward     (ws_forward),
        .debug_trace    (debug_trace)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .reset       (reset),
        .csr_raddr   (csr_raddr),
        .csr_rdata   (csr_rdata),
        .csr_wreq    (csr_wreq),
        .excp_req    (excp_req),
        .hard_int_in (hard_int_in),
        .ipi_int_in  (ipi_int_in),
        .era         (era),
        .eentry      (eentry),
        .has_int     (has_int)
    );

    regfile u_regfile (
        .clk    (clk),
        .wb_bus (wb_bus),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule

//--- bench/wb_model.svh
// ========================================================================
// reference state for the register file and CSRs
// ========================================================================
logic [31:0] m_rf [0:31];
logic [1:0]  m_plv;
logic        m_ie;
logic [1:0]  m_pplv;
logic        m_pie;
logic [12:0] m_lie;
logic [1:0]  m_is_sw;
logic [7:0]  m_is_hw;
logic        m_is_ipi;
logic [5:0]  m_ecode;
logic [31:0] m_era;
logic [31:0] m_badv;
logic [31:0] m_eentry;
logic [31:0] m_save [0:3];

task automatic reset_model;
    for (int i = 0; i < 32; i++) begin
        m_rf[i] = 'x;                // not reset in hardware
    end
    m_rf[0]  = 32'd0;
    m_plv    = 2'd0;
    m_ie     = 1'b0;
    m_pplv   = 2'd0;
    m_pie    = 1'b0;
    m_lie    = 13'd0;
    m_is_sw  = 2'd0;
    m_is_hw  = 8'd0;
    m_is_ipi = 1'b0;
    m_ecode  = 6'd0;
    m_era    = 32'd0;
    m_badv   = 'x;
    m_eentry = 32'd0;
    for (int i = 0; i < 4; i++) begin
        m_save[i] = 'x;
    end
endtask

function automatic logic [31:0] read_csr(input logic [13:0] addr);
    logic [12:0] is_bits;
    is_bits = {m_is_ipi, 2'b00, m_is_hw, m_is_sw};
    case (addr)
        csr_pkg::CSR_CRMD:   return {29'd0, m_ie, m_plv};
        csr_pkg::CSR_PRMD:   return {29'd0, m_pie, m_pplv};
        csr_pkg::CSR_ECFG:   return {19'd0, m_lie};
        csr_pkg::CSR_ESTAT:  return {10'd0, m_ecode, 3'd0, is_bits};   // esubcode stays 0
        csr_pkg::CSR_ERA:    return m_era;
        csr_pkg::CSR_BADV:   return m_badv;
        csr_pkg::CSR_EENTRY: return m_eentry;
        csr_pkg::CSR_SAVE0:  return m_save[0];
        csr_pkg::CSR_SAVE1:  return m_save[1];
        csr_pkg::CSR_SAVE2:  return m_save[2];
        csr_pkg::CSR_SAVE3:  return m_save[3];
        default:             return 32'd0;
    endcase
endfunction

function automatic logic pending_int;
    return m_ie && |({m_is_ipi, 2'b00, m_is_hw, m_is_sw} & m_lie);
endfunction

function automatic logic [5:0] expected_ecode(input logic [15:0] num);
    logic [5:0] code;
    code = 6'd0;
    // scan upward so the highest set bit wins
    for (int i = 1; i < 16; i++) begin
        if (num[i]) begin
            case (i)
                1:       code = csr_pkg::ECODE_PIL;
                2:       code = csr_pkg::ECODE_PIS;
                3:       code = csr_pkg::ECODE_PPI;
                4:       code = csr_pkg::ECODE_PME;
                5:       code = csr_pkg::ECODE_TLBR;
                6:       code = csr_pkg::ECODE_ALE;
                7:       code = csr_pkg::ECODE_IPE;
                8:       code = csr_pkg::ECODE_INE;
                9:       code = csr_pkg::ECODE_BRK;
                10:      code = csr_pkg::ECODE_SYS;
                11:      code = csr_pkg::ECODE_PPI;
                12:      code = csr_pkg::ECODE_PIF;
                13:      code = csr_pkg::ECODE_TLBR;
                14:      code = csr_pkg::ECODE_ADE;
                default: code = csr_pkg::ECODE_INT;
            endcase
        end
    end
    return code;
endfunction

// interrupt lines as seen by the edge
task automatic sample_int_lines(input logic rst, input logic [7:0] hw, input logic ipi);
    m_is_hw  = rst ? 8'd0 : hw;
    m_is_ipi = rst ? 1'b0 : ipi;
endtask

// one bundle leaving write-back at a clock edge
task automatic commit_bundle(input logic v, input cpu_pkg::ms_to_ws_t b);
    logic [31:0] wdata;
    logic [31:0] val;
    if (v) begin
        wdata = b.res_from_csr ? read_csr(b.csr_num) : b.result;
        if (b.excp) begin
            m_pplv  = m_plv;
            m_pie   = m_ie;
            m_plv   = 2'd0;
            m_ie    = 1'b0;
            m_era   = b.pc;
            m_ecode = expected_ecode(b.excp_num);
            if (m_ecode == csr_pkg::ECODE_ADE || m_ecode == csr_pkg::ECODE_ALE) begin
                m_badv = b.err_addr;
            end
        end else if (b.ertn) begin
            m_plv = m_pplv;
            m_ie  = m_pie;
        end else begin
            if (b.csr_we) begin
                val = (read_csr(b.csr_num) & ~b.csr_wmask) | (b.csr_wdata & b.csr_wmask);
                case (b.csr_num)
                    csr_pkg::CSR_CRMD:   {m_ie, m_plv} = val[2:0];
                    csr_pkg::CSR_PRMD:   {m_pie, m_pplv} = val[2:0];
                    csr_pkg::CSR_ECFG:   m_lie = val[12:0];
                    csr_pkg::CSR_ESTAT:  m_is_sw = val[1:0];    // soft bits only
                    csr_pkg::CSR_ERA:    m_era = val;
                    csr_pkg::CSR_BADV:   m_badv = val;
                    csr_pkg::CSR_EENTRY: m_eentry = val & 32'hffff_ffc0;
                    csr_pkg::CSR_SAVE0:  m_save[0] = val;
                    csr_pkg::CSR_SAVE1:  m_save[1] = val;
                    csr_pkg::CSR_SAVE2:  m_save[2] = val;
                    csr_pkg::CSR_SAVE3:  m_save[3] = val;
                    default: ;
                endcase
            end
            if (b.rf_we && b.dest != 5'd0) begin
                m_rf[b.dest] = wdata;
            end
        end
    end
endtask

//--- bench/tb_wb_top.sv
`timescale 1ns/1ps

module tb_wb_top;

    localparam int NUM_OPS    = 2000;
    localparam int MAX_CYCLES = 3000;   // margin over 10 reset + 32 init + ops + 45 final

    logic                  clk;
    logic                  reset;
    logic                  ms_to_ws_valid;
    cpu_pkg::ms_to_ws_t    ms_to_ws_bus;
    logic                  ws_allowin;
    logic [7:0]            hard_int_in;
    logic                  ipi_int_in;
    logic [4:0]            raddr1;
    logic [4:0]            raddr2;
    logic [31:0]           rdata1;
    logic [31:0]           rdata2;
    cpu_pkg::ws_forward_t  ws_forward;
    logic                  excp_flush;
    logic                  ertn_flush;
    logic                  ws_ex;
    logic [31:0]           era;
    logic [31:0]           eentry;
    logic                  has_int;
    cpu_pkg::debug_trace_t debug_trace;

    integer             seed;
    string              phase;
    int                 cycle_count = 0;
    int                 mismatch_count;
    int                 other_count;
    logic               reset_drv;
    logic               ws_v;               // bundle held in write-back this cycle
    cpu_pkg::ms_to_ws_t ws_b;

    `include "wb_model.svh"

    wb_top u_wb_top (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .hard_int_in    (hard_int_in),
        .ipi_int_in     (ipi_int_in),
        .raddr1         (raddr1),
        .raddr2         (raddr2),
        .rdata1         (rdata1),
        .rdata2         (rdata2),
        .ws_forward     (ws_forward),
        .excp_flush     (excp_flush),
        .ertn_flush     (ertn_flush),
        .ws_ex          (ws_ex),
        .era            (era),
        .eentry         (eentry),
        .has_int        (has_int),
        .debug_trace    (debug_trace)
    );

    always #20 clk = ~clk;

    task automatic print_counts;
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            other_count++;
            $display("timeout: run still going after %0d cycles", cycle_count);
            print_counts();
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch %s %s expected %h actual %h", phase, name, exp, act);
        end
    endtask

    function automatic logic [13:0] csr_at(input int idx);
        case (idx)
            0:       return csr_pkg::CSR_CRMD;
            1:       return csr_pkg::CSR_PRMD;
            2:       return csr_pkg::CSR_ECFG;
            3:       return csr_pkg::CSR_ESTAT;
            4:       return csr_pkg::CSR_ERA;
            5:       return csr_pkg::CSR_BADV;
            6:       return csr_pkg::CSR_EENTRY;
            7:       return csr_pkg::CSR_SAVE0;
            8:       return csr_pkg::CSR_SAVE1;
            9:       return csr_pkg::CSR_SAVE2;
            10:      return csr_pkg::CSR_SAVE3;
            11:      return 14'h002;                 // unlisted
            default: return 14'h3ff;
        endcase
    endfunction

    task automatic check_outputs;
        logic        we;
        logic [31:0] wdata;
        we    = ws_v && ws_b.rf_we && !ws_b.excp && !ws_b.ertn;
        wdata = ws_b.res_from_csr ? read_csr(ws_b.csr_num) : ws_b.result;
        compare_value("ws_allowin", 32'd1, ws_allowin);
        compare_value("excp_flush", ws_v && ws_b.excp, excp_flush);
        compare_value("ertn_flush", ws_v && ws_b.ertn, ertn_flush);
        compare_value("ws_ex", ws_v && (ws_b.excp || ws_b.ertn), ws_ex);
        compare_value("forward.valid", ws_v, ws_forward.valid);
        compare_value("trace.rf_we", {4{we}}, debug_trace.rf_we);
        if (ws_v) begin
            compare_value("forward.rf_we", ws_b.rf_we, ws_forward.rf_we);
            compare_value("forward.dest", ws_b.dest, ws_forward.dest);
            compare_value("forward.result", wdata, ws_forward.result);
        end
        if (we) begin
            compare_value("trace.pc", ws_b.pc, debug_trace.pc);
            compare_value("trace.inst", ws_b.inst, debug_trace.inst);
            compare_value("trace.rf_wnum", ws_b.dest, debug_trace.rf_wnum);
            compare_value("trace.rf_wdata", wdata, debug_trace.rf_wdata);
        end
        compare_value("era", m_era, era);
        compare_value("eentry", m_eentry, eentry);
        compare_value("has_int", pending_int(), has_int);
        // registers never written yet are skipped
        if (!$isunknown(m_rf[raddr1])) compare_value("rdata1", m_rf[raddr1], rdata1);
        if (!$isunknown(m_rf[raddr2])) compare_value("rdata2", m_rf[raddr2], rdata2);
    endtask

    // ========================================================================
    // one clock with model update at the edge, new drive and mid-cycle checks
    // ========================================================================
    task automatic run_cycle(input logic v, input cpu_pkg::ms_to_ws_t b,
                             input logic [7:0] hw, input logic ipi, input logic [4:0] ra2);
        @(posedge clk);
        #2;
        commit_bundle(ws_v, ws_b);
        sample_int_lines(reset, hard_int_in, ipi_int_in);
        raddr1 = ws_b.dest;                  // just committed
        ws_v   = ms_to_ws_valid && !reset;
        if (ms_to_ws_valid) begin
            ws_b = ms_to_ws_bus;
        end
        reset          = reset_drv;
        ms_to_ws_valid = v;
        ms_to_ws_bus   = b;
        hard_int_in    = hw;
        ipi_int_in     = ipi;
        raddr2         = ra2;
        #10;
        check_outputs();
    endtask

    task automatic make_op(output logic v, output cpu_pkg::ms_to_ws_t b,
                           inout logic [7:0] hw, inout logic ipi);
        int kind;
        b           = '0;
        b.pc        = {$random(seed)} & 32'hffff_fffc;
        b.inst      = $random(seed);
        b.dest      = $random(seed);
        b.result    = $random(seed);
        b.csr_num   = csr_at({$random(seed)} % 13);
        b.csr_wmask = $random(seed);
        b.csr_wdata = $random(seed);
        b.err_addr  = $random(seed);
        v           = ({$random(seed)} % 4) != 0;
        kind        = {$random(seed)} % 8;
        case (kind)
            0, 1: b.rf_we = 1'b1;
            2: begin                         // exchange returns the old value to rd
                b.csr_we       = 1'b1;
                b.rf_we        = 1'b1;
                b.res_from_csr = 1'b1;
            end
            3: begin
                b.rf_we        = 1'b1;
                b.res_from_csr = 1'b1;
            end
            4: begin
                b.excp     = 1'b1;
                b.rf_we    = 1'b1;
                b.csr_we   = $random(seed);
                b.excp_num = 16'h1 << (1 + {$random(seed)} % 15);
                if ($random(seed) & 1) begin
                    b.excp_num = b.excp_num | ($random(seed) & 16'hfffe);
                end
            end
            5: begin
                b.ertn  = 1'b1;
                b.rf_we = 1'b1;
            end
            default: begin                   // interrupt lines move
                b.rf_we = 1'b1;
                hw      = $random(seed);
                ipi     = $random(seed);
            end
        endcase
    endtask

    initial begin : stimulus
        cpu_pkg::ms_to_ws_t b;
        logic               v;
        logic [7:0]         hw;
        logic               ipi;
        seed           = 32'hf107;
        mismatch_count = 0;
        other_count    = 0;
        clk            = 1'b0;
        reset          = 1'b1;
        reset_drv      = 1'b1;
        ms_to_ws_valid = 1'b0;
        ms_to_ws_bus   = '0;
        hard_int_in    = 8'd0;
        ipi_int_in     = 1'b0;
        raddr1         = 5'd0;
        raddr2         = 5'd0;
        ws_v           = 1'b0;
        ws_b           = '0;
        hw             = 8'd0;
        ipi            = 1'b0;
        reset_model();

        phase = "reset";
        repeat (9) run_cycle(1'b0, '0, hw, ipi, 5'd0);
        reset_drv = 1'b0;                    // released after the tenth edge

        // every register and listed CSR gets a known value
        phase = "init";
        for (int i = 0; i < 32; i++) begin
            b           = '0;
            b.pc        = i * 4;
            b.rf_we     = 1'b1;
            b.dest      = i;
            b.result    = $random(seed);
            b.csr_we    = (i < 11);
            b.csr_num   = csr_at(i);
            b.csr_wmask = 32'hffff_ffff;
            b.csr_wdata = $random(seed);
            run_cycle(1'b1, b, hw, ipi, 5'd0);
        end

        phase = "random";
        for (int n = 0; n < NUM_OPS; n++) begin
            make_op(v, b, hw, ipi);
            run_cycle(v, b, hw, ipi, $random(seed));
        end

        phase = "final";
        for (int c = 0; c < 13; c++) begin
            b              = '0;
            b.rf_we        = 1'b1;
            b.res_from_csr = 1'b1;
            b.dest         = c + 1;
            b.csr_num      = csr_at(c);
            run_cycle(1'b1, b, hw, ipi, 5'd0);
        end
        for (int r = 0; r < 32; r++) begin
            run_cycle(1'b0, '0, hw, ipi, r);
        end

        print_counts();
        if (mismatch_count == 0 && other_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+bench
verilog/cpu_pkg.sv
verilog/csr_pkg.sv
verilog/regfile.sv
verilog/csr_file.sv
verilog/wb_stage.sv
verilog/wb_top.sv
bench/tb_wb_top.sv
